// File: Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - common

sources:
  - common/cpuPkg.sv
  - fetch/instrMem.sv
  - fetch/instrDecode.sv
  - fetch/fetchUnit.sv
  - hdl/instrQueue.sv
  - hdl/execUnit.sv
  - hdl/cpuCore.sv
  - target: test
    files:
      - test/tbClock.sv
      - test/cpuCore_props.sv
      - test/cpuCore_tb.sv

// File: common/cpuPkg.sv
/*
  Shared types of the core: opcode and ALU encodings, the decoded packet
  that travels from fetch through the queue to exec, and the redirect and
  retire records. Import it inside the module body of any user.
*/
`default_nettype none

`include "cpu_settings.svh"

package cpuPkg;

    localparam int REG_IDX_W = $clog2(`CPU_NUM_REGS);

    typedef logic [`CPU_XLEN-1:0] wordT;
    typedef logic [REG_IDX_W-1:0] regIdxT;

    // Opcode field, bits 15:11 of the instruction
    typedef enum logic [4:0] {
        OP_HALT  = 5'b00000,
        OP_NOP   = 5'b00001,
        OP_J     = 5'b00100,
        OP_JAL   = 5'b00110,
        OP_ADDI  = 5'b01000,
        OP_BEQZ  = 5'b01100,
        OP_LBI   = 5'b11000,
        OP_RTYPE = 5'b11011,
        OP_ERR   = 5'b11111  // Any opcode outside the supported set
    } opcodeT;

    // Same encoding as the R-type function field
    typedef enum logic [1:0] {
        ALU_ADD  = 2'b00,
        ALU_SUB  = 2'b01,
        ALU_XOR  = 2'b10,
        ALU_PASS = 2'b11
    } aluOpT;

    typedef struct packed {
        wordT   pc;
        opcodeT opcode;
        aluOpT  aluOp;
        regIdxT rs;
        regIdxT rt;
        regIdxT rd;        // Destination after the Rs/Rd-R/Rd-I/R7 select
        logic   regWrite;
        logic   useImm;
        wordT   imm;       // Already sign-extended
        logic   isBranch;
        logic   isJump;
        logic   isLink;
        logic   ctrlErr;
    } instrPktT;

    typedef struct packed {
        logic valid;
        wordT target;
    } redirectT;

    typedef struct packed {
        logic   valid;
        wordT   pc;
        logic   wrEn;
        regIdxT wrReg;
        wordT   wrData;
    } retireT;

endpackage

`default_nettype wire

// File: common/cpu_settings.svh
/*
  Global size settings for the 16-bit fetch/execute core.
  Include this wherever a width or a depth is needed; the types built on
  these values live in the core package.
*/
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Data and instruction word width
`define CPU_XLEN 16

// Instruction memory depth in 16-bit words
`define CPU_IMEM_WORDS 256

// Queue entries, also the full credit count of fetch
`define CPU_QUEUE_DEPTH 4

// Architectural registers R0..R7
`define CPU_NUM_REGS 8

`endif

// File: compile.f
+incdir+common
common/cpuPkg.sv
fetch/instrMem.sv
fetch/instrDecode.sv
fetch/fetchUnit.sv
hdl/instrQueue.sv
hdl/execUnit.sv
hdl/cpuCore.sv
test/tbClock.sv
test/cpuCore_props.sv
test/cpuCore_tb.sv

// File: fetch/fetchUnit.sv
/*
  Fetch stage. Holds the PC, reads the instruction memory, decodes the word
  and pushes one packet per cycle into the instruction queue under credit
  flow control. Stops after a HALT or a bad opcode until a redirect or reset.
*/
`default_nettype none
`timescale 1ns/1ps

`include "cpu_settings.svh"

module fetchUnit (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                progWe,
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] progAddr,
    input  logic [`CPU_XLEN-1:0]                progData,
    output logic                                push,
    output cpuPkg::instrPktT                    pushPkt,
    input  logic                                creditReturn,
    input  cpuPkg::redirectT                    redirect
);
    import cpuPkg::*;

    localparam int ADDR_W   = $clog2(`CPU_IMEM_WORDS);
    localparam int CREDIT_W = $clog2(`CPU_QUEUE_DEPTH + 1);
    localparam logic [CREDIT_W-1:0] FULL_CREDITS = CREDIT_W'(`CPU_QUEUE_DEPTH);

    wordT                pc;
    wordT                instr;
    instrPktT            decPkt;
    logic [CREDIT_W-1:0] credits;
    logic                stopped;   // Set by HALT or bad opcode
    logic                running;   // Low for the first cycle out of reset

    // Program port only takes effect while the core is held in reset
    instrMem InstrMem (
        .clk      (clk),
        .addr     (pc[ADDR_W:1]),  // Byte PC to word index
        .rdData   (instr),
        .progWe   (progWe & rst),
        .progAddr (progAddr),
        .progData (progData)
    );

    instrDecode Decoder (
        .instr (instr),
        .pc    (pc),
        .pkt   (decPkt)
    );

    assign push    = running && (credits != '0) && !stopped && !redirect.valid;
    assign pushPkt = decPkt;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= '0;
            credits <= FULL_CREDITS;
            stopped <= 1'b0;
            running <= 1'b0;
        end else begin
            running <= 1'b1;
            if (redirect.valid) begin
                // Queue is flushed on this edge, so all credits come back
                pc      <= redirect.target;
                credits <= FULL_CREDITS;
                stopped <= 1'b0;
            end else begin
                if (push) begin
                    pc <= pc + 16'd2;
                    if (decPkt.opcode == OP_HALT || decPkt.ctrlErr) begin
                        stopped <= 1'b1;
                    end
                end
                case ({push, creditReturn})
                    2'b10:   credits <= credits - 1'b1;
                    2'b01:   credits <= credits + 1'b1;
                    default: credits <= credits;  // Both or neither
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: fetch/instrDecode.sv
/*
  Combinational decoder. Turns one instruction word and its PC into a
  packet: control bits, operand and destination registers, and the
  immediate sign-extended for its format. Unknown opcodes set ctrlErr.
*/
`default_nettype none
`timescale 1ns/1ps

`include "cpu_settings.svh"

module instrDecode (
    input  logic [`CPU_XLEN-1:0] instr,
    input  logic [`CPU_XLEN-1:0] pc,
    output cpuPkg::instrPktT     pkt
);
    import cpuPkg::*;

    logic [4:0] opField;
    logic [1:0] dstSel;  // 00 Rs, 01 Rd-R, 10 R7, 11 Rd-I

    assign opField = instr[15:11];

    always_comb begin
        pkt        = '0;
        pkt.pc     = pc;
        pkt.opcode = opcodeT'(opField);
        pkt.aluOp  = ALU_PASS;
        pkt.rs     = instr[10:8];
        pkt.rt     = instr[7:5];
        dstSel     = 2'b01;
        case (opField)
            OP_HALT, OP_NOP: begin
            end
            OP_J: begin
                pkt.isJump = 1'b1;
                pkt.imm    = {{5{instr[10]}}, instr[10:0]};
            end
            OP_JAL: begin
                pkt.isJump   = 1'b1;
                pkt.isLink   = 1'b1;
                pkt.regWrite = 1'b1;
                pkt.imm      = {{5{instr[10]}}, instr[10:0]};
                dstSel       = 2'b10;
            end
            OP_ADDI: begin
                pkt.aluOp    = ALU_ADD;
                pkt.useImm   = 1'b1;
                pkt.regWrite = 1'b1;
                pkt.imm      = {{11{instr[4]}}, instr[4:0]};
                dstSel       = 2'b11;
            end
            OP_BEQZ: begin
                pkt.isBranch = 1'b1;
                pkt.imm      = {{8{instr[7]}}, instr[7:0]};
            end
            OP_LBI: begin
                pkt.useImm   = 1'b1;  // PASS forwards the immediate
                pkt.regWrite = 1'b1;
                pkt.imm      = {{8{instr[7]}}, instr[7:0]};
                dstSel       = 2'b00;
            end
            OP_RTYPE: begin
                pkt.aluOp    = aluOpT'(instr[1:0]);
                pkt.regWrite = (instr[1:0] != 2'b11);
                pkt.ctrlErr  = (instr[1:0] == 2'b11);  // No fourth function
            end
            default: begin
                pkt.opcode  = OP_ERR;
                pkt.ctrlErr = 1'b1;
            end
        endcase

        // Destination register select
        case (dstSel)
            2'b00:   pkt.rd = instr[10:8];
            2'b10:   pkt.rd = 3'd7;
            2'b11:   pkt.rd = instr[7:5];
            default: pkt.rd = instr[4:2];
        endcase
    end

endmodule

`default_nettype wire

// File: fetch/instrMem.sv
/*
  Word-addressed instruction memory. Reads are asynchronous so the fetched
  word belongs to the current PC in the same cycle; the program port writes
  one word per clock.
*/
`default_nettype none
`timescale 1ns/1ps

`include "cpu_settings.svh"

module instrMem (
    input  logic                                clk,
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] addr,
    output logic [`CPU_XLEN-1:0]                rdData,
    input  logic                                progWe,
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] progAddr,
    input  logic [`CPU_XLEN-1:0]                progData
);

    logic [`CPU_XLEN-1:0] mem [`CPU_IMEM_WORDS];

    // Program load
    always_ff @(posedge clk) begin
        if (progWe) begin
            mem[progAddr] <= progData;
        end
    end

    assign rdData = mem[addr];  // Combinational fetch

endmodule

`default_nettype wire

// File: hdl/cpuCore.sv
/*
  Top level of the core. Fetch feeds the instruction queue under credits,
  exec drains it and sends redirects back; a redirect also flushes the
  queue. Programs are loaded through the program port while rst is high.
*/
`default_nettype none
`timescale 1ns/1ps

`include "cpu_settings.svh"

module cpuCore (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                progWe,
    input  logic [$clog2(`CPU_IMEM_WORDS)-1:0] progAddr,
    input  logic [`CPU_XLEN-1:0]                progData,
    output cpuPkg::retireT                      retire,
    output logic                                halted,
    output logic                                err
);
    import cpuPkg::*;

    logic     push;
    instrPktT pushPkt;
    logic     creditReturn;
    redirectT redirect;
    logic     headValid;
    instrPktT headPkt;
    logic     pop;

    fetchUnit fetch (
        .clk          (clk),
        .rst          (rst),
        .progWe       (progWe),
        .progAddr     (progAddr),
        .progData     (progData),
        .push         (push),
        .pushPkt      (pushPkt),
        .creditReturn (creditReturn),
        .redirect     (redirect)
    );

    instrQueue #(
        .T     (instrPktT),
        .DEPTH (`CPU_QUEUE_DEPTH)
    ) queue (
        .clk          (clk),
        .rst          (rst),
        .flush        (redirect.valid),
        .push         (push),
        .pushData     (pushPkt),
        .pop          (pop),
        .headValid    (headValid),
        .headData     (headPkt),
        .creditReturn (creditReturn)
    );

    execUnit exec (
        .clk       (clk),
        .rst       (rst),
        .headValid (headValid),
        .headPkt   (headPkt),
        .pop       (pop),
        .redirect  (redirect),
        .retire    (retire),
        .halted    (halted),
        .err       (err)
    );

endmodule

`default_nettype wire

// File: hdl/execUnit.sv
/*
  Execute stage. Pops the queue head, reads the register file, runs the ALU
  and writes back in one cycle. Taken branches and jumps raise a registered
  redirect; the retire record follows the pop by one cycle. HALT or a bad
  opcode stops all further popping.
*/
`default_nettype none
`timescale 1ns/1ps

`include "cpu_settings.svh"

module execUnit (
    input  logic             clk,
    input  logic             rst,
    input  logic             headValid,
    input  cpuPkg::instrPktT headPkt,
    output logic             pop,
    output cpuPkg::redirectT redirect,
    output cpuPkg::retireT   retire,
    output logic             halted,
    output logic             err
);
    import cpuPkg::*;

    wordT regFile [`CPU_NUM_REGS];
    wordT opA;
    wordT opB;
    wordT aluOut;
    wordT wrData;
    wordT seqPc;
    wordT target;
    logic taken;
    logic wrEn;
    logic stopNow;

    // Nothing pops while a redirect flushes the wrong path
    assign pop = headValid && !halted && !redirect.valid;

    assign opA = regFile[headPkt.rs];
    assign opB = headPkt.useImm ? headPkt.imm : regFile[headPkt.rt];

    always_comb begin
        case (headPkt.aluOp)
            ALU_ADD: aluOut = opA + opB;
            ALU_SUB: aluOut = opA - opB;  // Rs minus Rt
            ALU_XOR: aluOut = opA ^ opB;
            default: aluOut = opB;
        endcase
    end

    assign seqPc   = headPkt.pc + 16'd2;
    assign target  = seqPc + headPkt.imm;
    assign wrData  = headPkt.isLink ? seqPc : aluOut;  // JAL links to PC+2
    assign taken   = headPkt.isJump || (headPkt.isBranch && (opA == '0));
    assign stopNow = (headPkt.opcode == OP_HALT) || headPkt.ctrlErr;
    assign wrEn    = headPkt.regWrite && !headPkt.ctrlErr;

    always_ff @(posedge clk) begin
        if (rst) begin
            retire   <= '0;
            redirect <= '0;
            halted   <= 1'b0;
            err      <= 1'b0;
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            retire.valid   <= pop;
            redirect.valid <= pop && taken;
            if (pop) begin
                retire.pc       <= headPkt.pc;
                retire.wrEn     <= wrEn;
                retire.wrReg    <= headPkt.rd;
                retire.wrData   <= wrData;
                redirect.target <= target;
                if (wrEn) begin
                    regFile[headPkt.rd] <= wrData;
                end
                if (stopNow) halted <= 1'b1;
                if (headPkt.ctrlErr) err <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/instrQueue.sv
/*
  Circular FIFO, generic over its payload type. A pushed entry shows at the
  head on the next cycle. Every pop returns one credit to the producer in
  the same cycle; flush drops all entries and any push on that edge.
*/
`default_nettype none
`timescale 1ns/1ps

module instrQueue #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic flush,
    input  logic push,
    input  T     pushData,
    input  logic pop,
    output logic headValid,
    output T     headData,
    output logic creditReturn
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T                 buffer [DEPTH];
    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W:0]   count;
    logic             doPush;
    logic             doPop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign headValid    = (count != '0);
    assign headData     = buffer[rdPtr];
    assign doPush       = push && !flush && (count != (PTR_W + 1)'(DEPTH));
    assign doPop        = pop && headValid;
    assign creditReturn = doPop;

    always_ff @(posedge clk) begin
        if (doPush) begin
            buffer[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= nextPtr(wrPtr);
            if (doPop)  rdPtr <= nextPtr(rdPtr);
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: test/cpuCore_props.sv
/*
  Flow-control properties of the core. One copy is bound into the fetch
  stage for the credit count, one into the instruction queue for push,
  pop and credit return. Each failure also bumps failCount, which the
  testbench reads at the end of the run.
*/
`default_nettype none
`timescale 1ns/1ps

`include "cpu_settings.svh"

module cpuCore_props #(
    parameter int DEPTH      = 4,
    parameter bit QUEUE_SIDE = 1'b0
) (
    input logic                         clk,
    input logic                         rst,
    input logic [$clog2(DEPTH+1)-1:0] credits,
    input logic [$clog2(DEPTH+1)-1:0] count,
    input logic                         push,
    input logic                         flush,
    input logic                         pop,
    input logic                         creditReturn
);

    int failCount = 0;

    if (QUEUE_SIDE) begin : queueChecks
        // A flushing edge drops the push, so only a real push counts
        pushNotFull: assert property (@(posedge clk) disable iff (rst)
            (push && !flush) |-> (count < DEPTH))
        else begin
            failCount++;
            $error("push into a full queue");
        end

        popNotEmpty: assert property (@(posedge clk) disable iff (rst) pop |-> (count != '0))
        else begin
            failCount++;
            $error("pop from an empty queue");
        end

        creditFollowsPop: assert property (@(posedge clk) disable iff (rst)
            creditReturn == pop)
        else begin
            failCount++;
            $error("credit return differs from pop");
        end
    end else begin : creditChecks  // Fetch side
        creditLimit: assert property (@(posedge clk) disable iff (rst) credits <= DEPTH)
        else begin
            failCount++;
            $error("fetch credit count above queue depth");
        end
    end

endmodule

bind fetchUnit cpuCore_props #(
    .DEPTH      (`CPU_QUEUE_DEPTH),
    .QUEUE_SIDE (1'b0)
) fetchProps (
    .clk          (clk),
    .rst          (rst),
    .credits      (credits),
    .count        ('0),
    .push         (1'b0),
    .flush        (1'b0),
    .pop          (1'b0),
    .creditReturn (1'b0)
);

bind instrQueue cpuCore_props #(
    .DEPTH      (DEPTH),
    .QUEUE_SIDE (1'b1)
) queueProps (
    .clk          (clk),
    .rst          (rst),
    .credits      ('0),
    .count        (count),
    .push         (push),
    .flush        (flush),
    .pop          (pop),
    .creditReturn (creditReturn)
);

`default_nettype wire

// File: test/cpuCore_tb.sv
/*
  Directed testbench for the core. Each test loads a program through the
  program port under reset, runs it until the core halts and compares the
  retire trace with an ISA model kept here. The last test is a straight-line
  program built from LFSR bits.
*/
`default_nettype none
`timescale 1ns/1ps

`include "cpu_settings.svh"

module cpuCore_tb;
    import cpuPkg::*;

    localparam int ADDR_W        = $clog2(`CPU_IMEM_WORDS);
    localparam int CLK_PERIOD_NS = 8;
    localparam int TOTAL_INSTR   = 76;  // Sum of all program lengths below
    localparam int WATCHDOG_NS   = TOTAL_INSTR * 20 * CLK_PERIOD_NS;

    localparam logic [4:0]  OPC_J     = 5'b00100;
    localparam logic [4:0]  OPC_JAL   = 5'b00110;
    localparam logic [4:0]  OPC_BEQZ  = 5'b01100;
    localparam logic [4:0]  OPC_LBI   = 5'b11000;
    localparam logic [15:0] HALT_WORD = 16'h0000;

    logic                 clk;
    logic                 porRst;
    logic                 testRst;
    logic                 rst;
    logic                 progWe;
    logic [ADDR_W-1:0]    progAddr;
    logic [`CPU_XLEN-1:0] progData;
    retireT               retire;
    logic                 halted;
    logic                 err;

    logic [15:0] progImg [`CPU_IMEM_WORDS];
    int          progLen;
    retireT      expQ [$];
    retireT      actQ [$];
    logic        modelErr;
    logic [31:0] lfsrState = 32'hd531;
    int          checkCount = 0;
    int          errorCount = 0;
    int          assertFails;

    assign rst = porRst | testRst;

    tbClock clockGen (
        .clk (clk),
        .rst (porRst)
    );

    cpuCore UUT (
        .clk      (clk),
        .rst      (rst),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .retire   (retire),
        .halted   (halted),
        .err      (err)
    );

    // Retire trace, sampled on the falling edge
    always @(negedge clk) begin
        if (retire.valid) begin
            actQ.push_back(retire);
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [15:0] randBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return v;
    endfunction

    function automatic logic [15:0] encImm8(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic logic [15:0] encAddi(input logic [2:0] rs, input logic [2:0] rd,
                                            input logic [4:0] imm);
        return {5'b01000, rs, rd, imm};
    endfunction

    function automatic logic [15:0] encRtype(input logic [2:0] rs, input logic [2:0] rt,
                                             input logic [2:0] rd, input logic [1:0] fn);
        return {5'b11011, rs, rt, rd, fn};
    endfunction

    function automatic logic [15:0] encJump(input logic [4:0] op, input logic [10:0] disp);
        return {op, disp};
    endfunction

    task automatic addInstr(input logic [15:0] w);
        progImg[progLen] = w;
        progLen++;
    endtask

    task automatic expectEqual(input string testName, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("[FAIL] %s %s: expected %h, actual %h", testName, what, expected, actual);
        end
    endtask

    // ISA reference, walks the image from PC 0 until HALT or a bad opcode
    task automatic modelRun();
        logic [15:0] regs [8];
        logic [15:0] pc;
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] seq;
        retireT      r;
        logic        stop;
        int          steps;
        for (int k = 0; k < 8; k++) begin
            regs[k] = '0;
        end
        pc = '0;
        stop = 1'b0;
        steps = 0;
        modelErr = 1'b0;
        expQ.delete();
        while (!stop && steps < `CPU_IMEM_WORDS) begin
            w = progImg[pc[ADDR_W:1]];
            a = regs[w[10:8]];
            b = regs[w[7:5]];
            seq = pc + 16'd2;
            r = '0;
            r.valid = 1'b1;
            r.pc = pc;
            pc = seq;
            case (w[15:11])
                5'b00000: stop = 1'b1;
                5'b00001: ;
                5'b00100: pc = seq + {{5{w[10]}}, w[10:0]};
                5'b00110: begin
                    pc = seq + {{5{w[10]}}, w[10:0]};
                    r.wrEn = 1'b1;
                    r.wrReg = 3'd7;
                    r.wrData = seq;  // Link is PC+2
                end
                5'b01000: begin
                    r.wrEn = 1'b1;
                    r.wrReg = w[7:5];
                    r.wrData = a + {{11{w[4]}}, w[4:0]};
                end
                5'b01100: begin
                    if (a == '0) pc = seq + {{8{w[7]}}, w[7:0]};
                end
                5'b11000: begin
                    r.wrEn = 1'b1;
                    r.wrReg = w[10:8];
                    r.wrData = {{8{w[7]}}, w[7:0]};
                end
                5'b11011: begin
                    r.wrEn = (w[1:0] != 2'b11);
                    r.wrReg = w[4:2];
                    r.wrData = (w[1:0] == 2'b00) ? a + b : (w[1:0] == 2'b01) ? a - b : a ^ b;
                    stop = !r.wrEn;  // Function 11 is undefined
                    modelErr = !r.wrEn;
                end
                default: begin
                    stop = 1'b1;
                    modelErr = 1'b1;
                end
            endcase
            if (r.wrEn) regs[r.wrReg] = r.wrData;
            expQ.push_back(r);
            steps++;
        end
    endtask

    task automatic loadProgram();
        @(negedge clk);
        testRst = 1'b1;
        for (int i = 0; i < progLen; i++) begin
            progWe   = 1'b1;
            progAddr = ADDR_W'(i);
            progData = progImg[i];
            @(negedge clk);
        end
        progWe  = 1'b0;
        testRst = 1'b0;
    endtask

    task automatic runProgram(input string name);
        int waited;
        int limit;
        int n;
        modelRun();
        actQ.delete();
        loadProgram();
        limit = progLen * 20;
        waited = 0;
        while (!halted && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (!halted) begin
            errorCount++;
            $display("%s: core did not halt within %0d cycles", name, limit);
        end
        // Nothing may retire while the core sits halted
        repeat (2 * `CPU_QUEUE_DEPTH + 4) @(negedge clk);
        expectEqual(name, "retire count", expQ.size(), actQ.size());
        n = (expQ.size() < actQ.size()) ? expQ.size() : actQ.size();
        for (int i = 0; i < n; i++) begin
            expectEqual(name, $sformatf("retire %0d pc", i), expQ[i].pc, actQ[i].pc);
            expectEqual(name, $sformatf("retire %0d wrEn", i), expQ[i].wrEn, actQ[i].wrEn);
            if (expQ[i].wrEn) begin
                expectEqual(name, $sformatf("retire %0d wrReg", i), expQ[i].wrReg, actQ[i].wrReg);
                expectEqual(name, $sformatf("retire %0d wrData", i), expQ[i].wrData,
                            actQ[i].wrData);
            end
        end
        expectEqual(name, "halted", 1, halted);
        expectEqual(name, "err", modelErr, err);
    endtask

    task automatic aluSequenceTest();
        progLen = 0;
        addInstr(encImm8(OPC_LBI, 3'd1, 8'd5));
        addInstr(encImm8(OPC_LBI, 3'd2, 8'hfd));
        addInstr(encAddi(3'd1, 3'd3, 5'd7));
        addInstr(encRtype(3'd1, 3'd2, 3'd4, 2'b00));
        addInstr(encRtype(3'd1, 3'd2, 3'd5, 2'b01));
        addInstr(encRtype(3'd3, 3'd4, 3'd6, 2'b10));
        addInstr(encAddi(3'd6, 3'd6, 5'h10));  // Minus 16
        addInstr(HALT_WORD);
        runProgram("aluSequence");
    endtask

    task automatic branchJumpTest();
        progLen = 0;
        addInstr(encImm8(OPC_LBI, 3'd1, 8'd0));
        addInstr(encImm8(OPC_LBI, 3'd2, 8'd9));
        addInstr(encImm8(OPC_BEQZ, 3'd1, 8'd4));  // Taken over the next two
        addInstr(encImm8(OPC_LBI, 3'd3, 8'd1));
        addInstr(encImm8(OPC_LBI, 3'd3, 8'd2));
        addInstr(encImm8(OPC_BEQZ, 3'd2, 8'd4));  // Not taken
        addInstr(encJump(OPC_J, 11'd4));
        addInstr(encImm8(OPC_LBI, 3'd4, 8'd3));
        addInstr(encImm8(OPC_LBI, 3'd4, 8'd4));
        addInstr(encAddi(3'd2, 3'd5, 5'd1));
        addInstr(HALT_WORD);
        runProgram("branchJump");
    endtask

    task automatic jalTest();
        progLen = 0;
        addInstr(encImm8(OPC_LBI, 3'd1, 8'd4));
        addInstr(encJump(OPC_JAL, 11'd4));
        addInstr(encImm8(OPC_LBI, 3'd1, 8'd1));
        addInstr(HALT_WORD);                   // Wrong path, must not stop the core
        addInstr(encAddi(3'd7, 3'd2, 5'd0));
        addInstr(HALT_WORD);
        runProgram("jal");
    endtask

    task automatic haltBackPressureTest();
        progLen = 0;
        addInstr(encImm8(OPC_LBI, 3'd1, 8'd1));
        addInstr(HALT_WORD);
        addInstr(encImm8(OPC_LBI, 3'd2, 8'd2));
        addInstr(encImm8(OPC_LBI, 3'd3, 8'd3));
        addInstr(encImm8(OPC_LBI, 3'd4, 8'd4));
        runProgram("haltBackPressure");
    endtask

    task automatic errorOpcodeTest();
        progLen = 0;
        addInstr(encImm8(OPC_LBI, 3'd1, 8'd7));
        addInstr(encAddi(3'd1, 3'd2, 5'd1));
        addInstr(16'ha800);  // Opcode 10101
        addInstr(encImm8(OPC_LBI, 3'd3, 8'd1));
        addInstr(HALT_WORD);
        runProgram("errorOpcode");
    endtask

    task automatic randomRunTest();
        logic [1:0] kind;
        logic [1:0] fn;
        progLen = 0;
        repeat (40) begin
            kind = 2'(randBits(2));
            case (kind)
                2'd0: addInstr(encImm8(OPC_LBI, 3'(randBits(3)), 8'(randBits(8))));
                2'd1: addInstr(encAddi(3'(randBits(3)), 3'(randBits(3)), 5'(randBits(5))));
                default: begin
                    fn = 2'(randBits(2));
                    if (fn == 2'b11) fn = 2'b10;
                    addInstr(encRtype(3'(randBits(3)), 3'(randBits(3)), 3'(randBits(3)), fn));
                end
            endcase
        end
        addInstr(HALT_WORD);
        runProgram("randomRun");
    endtask

    initial begin
        testRst  = 1'b0;
        progWe   = 1'b0;
        progAddr = '0;
        progData = '0;
        wait (porRst === 1'b0);
        aluSequenceTest();
        branchJumpTest();
        jalTest();
        haltBackPressureTest();
        errorOpcodeTest();
        randomRunTest();
        assertFails = UUT.fetch.fetchProps.failCount + UUT.queue.queueProps.failCount;
        $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
                 checkCount, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/tbClock.sv
/*
  Clock and power-on reset for the testbench. 8 ns period, reset held
  high for the first 10 rising edges and released on a falling edge.
*/
`default_nettype none
`timescale 1ns/1ps

module tbClock #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);  // Release away from the active edge
        rst = 1'b0;
    end

endmodule

`default_nettype wire
